//--- btb_consts.svh
/* sizing constants for the btb fetch front end
   include in any file that needs widths, depths or the reset pc */
`ifndef BTB_CONSTS_SVH
`define BTB_CONSTS_SVH

// ============================================================
// address and group geometry
// ============================================================
`define PC_WIDTH      32            // fetch address bits
`define BTB_SLOTS     4             // instruction slots per fetch group
`define INSN_BYTES    6             // bytes per instruction slot

// ============================================================
// storage
// ============================================================
`define BTB_DEPTH     1024          // entries per bank, power of two
`define BTB_INDEX_LSB 1             // lowest pc bit feeding the bank index
`define RAS_DEPTH     32            // return stack entries, power of two

// first fetch address out of reset
`define RESET_PC      32'h0000_0100

`endif

//--- fetch_pkg.sv
/* fetch address types shared by the next-pc logic, the btb and the return stack
   pull in with a wildcard import inside the module body */
`default_nettype none

`include "btb_consts.svh"

package fetch_pkg;

  // one fetch address, byte granular
  typedef logic [`PC_WIDTH-1:0] pc_t;

  // group length code, k means k+1 valid instructions
  typedef logic [1:0] insn_count_t;

endpackage

`default_nettype wire

//--- btb_pkg.sv
/* btb storage types: bank index, entry layout and per-slot vectors
   pull in with a wildcard import inside the module body */
`default_nettype none

`include "btb_consts.svh"

package btb_pkg;

  // bank address, same width for every bank
  typedef logic [$clog2(`BTB_DEPTH)-1:0] btb_index_t;

  // one bank entry
  typedef struct packed {
    logic            takb;          // branch was taken at commit
    fetch_pkg::pc_t  tag;           // full pc of the branch slot
    fetch_pkg::pc_t  tgt;           // taken target
  } btb_entry_t;

  // one bit per fetch group slot
  typedef logic [`BTB_SLOTS-1:0] slot_vec_t;

  // all banks are addressed by the group pc, low bit skipped
  function automatic btb_index_t btb_index(fetch_pkg::pc_t pc);
    return pc[`BTB_INDEX_LSB +: $clog2(`BTB_DEPTH)];
  endfunction

endpackage

`default_nettype wire

//--- btb_ifs.sv
/* interfaces between the btb pipeline stages
   btb_wr_if carries commit writes, btb_hit_if carries lookup results and the read pc */
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

// ============================================================
// commit stage -> banks, no handshake, banks always accept
// ============================================================
interface btb_wr_if;
  import btb_pkg::*;

  slot_vec_t                    wr_en;      // one write strobe per bank
  btb_index_t                   wr_index;   // shared index, from the group base
  btb_entry_t [`BTB_SLOTS-1:0]  wr_entry;   // per-slot entry

  modport src (output wr_en, output wr_index, output wr_entry);
  modport dst (input wr_en, input wr_index, input wr_entry);
endinterface

// ============================================================
// lookup stage <-> next-pc select
// ============================================================
interface btb_hit_if;
  import fetch_pkg::*;
  import btb_pkg::*;

  slot_vec_t              hit;      // slot tag matched and taken
  pc_t [`BTB_SLOTS-1:0]   target;   // bank targets, valid where hit set
  pc_t                    rd_pc;    // pc that fetch is about to take

  modport src (output hit, output target, input rd_pc);
  modport dst (input hit, input target, output rd_pc);
endinterface

`default_nettype wire

//--- btb_commit_stage.sv
/* captures one committed fetch group per cycle and turns it into bank writes
   the write lands on the edge after the commit is sampled */
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module btb_commit_stage (
  input  wire                                     clk,
  input  wire                                     rst,
  input  wire                                     commit_valid,
  input  wire fetch_pkg::pc_t                     commit_pc,    // group base
  input  wire btb_pkg::slot_vec_t                 commit_takb,
  input  wire fetch_pkg::pc_t [`BTB_SLOTS-1:0]    commit_tgt,
  btb_wr_if.src                                   wr
);
  import fetch_pkg::*;
  import btb_pkg::*;

  // strobes, only taken slots of a valid commit write their bank
  always_ff @(posedge clk) begin
    if (rst) begin
      wr.wr_en <= '0;
    end else begin
      wr.wr_en <= commit_valid ? commit_takb : '0;
    end
  end

  // payload, index from the base pc and tag from the slot pc
  always_ff @(posedge clk) begin
    wr.wr_index <= btb_index(commit_pc);
    for (int i = 0; i < `BTB_SLOTS; i++) begin
      wr.wr_entry[i].takb <= commit_takb[i];
      wr.wr_entry[i].tag  <= commit_pc + pc_t'(i * `INSN_BYTES);  // slot i address
      wr.wr_entry[i].tgt  <= commit_tgt[i];
    end
  end

endmodule

`default_nettype wire

//--- btb_bank.sv
/* one slot's btb memory, simple dual port with a one cycle registered read
   read-first, so a same-edge read of the written index sees the old entry */
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module btb_bank #(
  parameter int DEPTH = `BTB_DEPTH        // any power of two
) (
  input  wire                              clk,
  input  wire                              we,
  input  wire [$clog2(DEPTH)-1:0]          wr_index,
  input  wire btb_pkg::btb_entry_t         wr_entry,
  input  wire [$clog2(DEPTH)-1:0]          rd_index,
  output btb_pkg::btb_entry_t              rd_entry
);
  import btb_pkg::*;

  btb_entry_t mem [DEPTH];

  // start empty so nothing hits before its first commit
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_index] <= wr_entry;
    end
  end

  // read port, nonblocking gives old data on a collision
  always_ff @(posedge clk) begin
    rd_entry <= mem[rd_index];
  end

endmodule

`default_nettype wire

//--- btb_lookup_stage.sv
/* holds one btb bank per slot and resolves per-slot hits for the current fetch group
   banks are read ahead with rd_pc so their output lines up with fetch_pc */
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module btb_lookup_stage (
  input  wire                    clk,
  input  wire fetch_pkg::pc_t    fetch_pc,      // group now being fetched
  btb_wr_if.dst                  wr,
  btb_hit_if.src                 hits
);
  import fetch_pkg::*;
  import btb_pkg::*;

  btb_index_t  rd_index;                  // shared read address
  btb_entry_t  rd_entry [`BTB_SLOTS];     // registered bank outputs
  pc_t         slot_pc  [`BTB_SLOTS];     // address of each slot in the group

  // next fetch pc indexes every bank, one cycle ahead
  assign rd_index = btb_index(hits.rd_pc);

  // ============================================================
  // banks
  // ============================================================
  for (genvar g = 0; g < `BTB_SLOTS; g++) begin : g_bank
    btb_bank #(
      .DEPTH    (`BTB_DEPTH)
    ) bank_i (
      .clk      (clk),
      .we       (wr.wr_en[g]),
      .wr_index (wr.wr_index),
      .wr_entry (wr.wr_entry[g]),
      .rd_index (rd_index),
      .rd_entry (rd_entry[g])
    );
  end

  // ============================================================
  // tag compare
  // ============================================================
  always_comb begin
    for (int i = 0; i < `BTB_SLOTS; i++) begin
      slot_pc[i] = fetch_pc + pc_t'(i * `INSN_BYTES);
    end
  end

  // full pc tag, so an aliased index never hits
  always_comb begin
    for (int i = 0; i < `BTB_SLOTS; i++) begin
      hits.hit[i]    = rd_entry[i].takb && (rd_entry[i].tag == slot_pc[i]);
      hits.target[i] = rd_entry[i].tgt;     // don't care unless hit
    end
  end

endmodule

`default_nettype wire

//--- return_stack.sv
/* return address stack, pushed on a call and popped on a return
   top_pc is the entry at the pointer, a pop wins over a same-cycle push */
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module return_stack #(
  parameter int DEPTH = `RAS_DEPTH        // power of two, pointer wraps
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    push,
  input  wire fetch_pkg::pc_t    push_pc,
  input  wire                    pop,
  output fetch_pkg::pc_t         top_pc
);
  import fetch_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  pc_t              stack_mem [DEPTH];
  logic [PTR_W-1:0] sp;                   // points at the newest entry

  assign top_pc = stack_mem[sp];          // value a pop hands out

  // pointer grows downward, overflow just wraps
  always_ff @(posedge clk) begin
    if (rst) begin
      sp <= '0;
    end else if (pop) begin
      sp <= sp + PTR_W'(1);
    end else if (push) begin
      sp <= sp - PTR_W'(1);
    end
  end

  // push writes just below the pointer
  always_ff @(posedge clk) begin
    if (push && !pop) begin
      stack_mem[sp - PTR_W'(1)] <= push_pc;
    end
  end

endmodule

`default_nettype wire

//--- next_pc_select.sv
/* next fetch address by priority and the fetch pc register
   return, then miss, then lowest btb hit, then sequential; adv low holds */
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module next_pc_select (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          fetch_en,
  input  wire                          adv,          // group may advance
  input  wire fetch_pkg::insn_count_t  insn_count,
  input  wire                          do_ret,
  input  wire fetch_pkg::pc_t          ras_pc,
  input  wire                          miss_valid,
  input  wire fetch_pkg::pc_t          miss_pc,
  btb_hit_if.dst                       hits,
  output fetch_pkg::pc_t               fetch_pc,
  output btb_pkg::slot_vec_t           takb
);
  import fetch_pkg::*;
  import btb_pkg::*;

  logic      redirect;      // return or miss this cycle
  slot_vec_t hit_ok;        // hits that fetch may act on
  slot_vec_t first_hit;     // one-hot, lowest hitting slot
  pc_t       hit_tgt;       // target of first_hit
  pc_t       seq_pc;        // fall-through address
  pc_t       next_pc;

  assign redirect = do_ret | miss_valid;
  assign hit_ok   = fetch_en ? hits.hit : '0;

  // isolate lowest set bit, x & -x
  assign first_hit = hit_ok & (~hit_ok + 1'b1);

  // a redirect overrides any prediction in the same cycle
  assign takb = redirect ? '0 : first_hit;

  always_comb begin
    hit_tgt = '0;
    for (int i = 0; i < `BTB_SLOTS; i++) begin
      if (first_hit[i]) begin
        hit_tgt = hits.target[i];
      end
    end
  end

  // insn_count+1 instructions in the group
  assign seq_pc = fetch_pc + pc_t'(`INSN_BYTES) * (pc_t'(insn_count) + pc_t'(1));

  // ============================================================
  // priority mux
  // ============================================================
  always_comb begin
    if (do_ret) begin
      next_pc = ras_pc;             // popped at this edge
    end else if (miss_valid) begin
      next_pc = miss_pc;
    end else if (!adv) begin
      next_pc = fetch_pc;           // back-pressure, hold
    end else if (|first_hit) begin
      next_pc = hit_tgt;
    end else begin
      next_pc = seq_pc;
    end
  end

  // banks read the pc fetch is about to take
  assign hits.rd_pc = next_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc <= `RESET_PC;
    end else begin
      fetch_pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- btb_fetch_top.sv
/* rtl top of the btb fetch front end
   wires commit capture, banks and lookup, return stack and next-pc select together */
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module btb_fetch_top (
  input  wire                                    clk,
  input  wire                                    rst,
  input  wire                                    fetch_en,
  input  wire                                    adv,
  input  wire fetch_pkg::insn_count_t            insn_count,
  input  wire                                    miss_valid,
  input  wire fetch_pkg::pc_t                    miss_pc,
  input  wire                                    do_call,
  input  wire fetch_pkg::pc_t                    ret_pc,
  input  wire                                    do_ret,
  // commit side
  input  wire                                    commit_valid,
  input  wire fetch_pkg::pc_t                    commit_pc,
  input  wire btb_pkg::slot_vec_t                commit_takb,
  input  wire fetch_pkg::pc_t [`BTB_SLOTS-1:0]   commit_tgt,
  // fetch side
  output fetch_pkg::pc_t                         fetch_pc,
  output btb_pkg::slot_vec_t                     takb
);
  import fetch_pkg::*;

  pc_t ras_pc;              // top of return stack

  btb_wr_if  wr_bus ();
  btb_hit_if hit_bus ();

  btb_commit_stage commit_stage_i (
    .clk          (clk),
    .rst          (rst),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_takb  (commit_takb),
    .commit_tgt   (commit_tgt),
    .wr           (wr_bus.src)
  );

  btb_lookup_stage lookup_stage_i (
    .clk      (clk),
    .fetch_pc (fetch_pc),
    .wr       (wr_bus.dst),
    .hits     (hit_bus.src)
  );

  return_stack #(
    .DEPTH   (`RAS_DEPTH)
  ) return_stack_i (
    .clk     (clk),
    .rst     (rst),
    .push    (do_call),
    .push_pc (ret_pc),
    .pop     (do_ret),
    .top_pc  (ras_pc)
  );

  next_pc_select next_pc_select_i (
    .clk        (clk),
    .rst        (rst),
    .fetch_en   (fetch_en),
    .adv        (adv),
    .insn_count (insn_count),
    .do_ret     (do_ret),
    .ras_pc     (ras_pc),
    .miss_valid (miss_valid),
    .miss_pc    (miss_pc),
    .hits       (hit_bus.dst),
    .fetch_pc   (fetch_pc),
    .takb       (takb)
  );

endmodule

`default_nettype wire

//--- tb_btb_fetch.sv
/* self-checking testbench for the btb fetch front end
   random fetch, commit, miss and call/return traffic checked against a reference model */
`timescale 1ns/1ps
`default_nettype none

`include "btb_consts.svh"

module tb_btb_fetch;
  import fetch_pkg::*;
  import btb_pkg::*;

  localparam int SLOT_W = $clog2(`BTB_SLOTS);
  localparam int IDX_W  = $clog2(`BTB_DEPTH);
  typedef logic [SLOT_W+`PC_WIDTH-1:0] key_t;     // {slot, slot pc}

  logic                  clk;
  logic                  rst;
  logic                  fetch_en;
  logic                  adv;
  insn_count_t           insn_count;
  logic                  miss_valid;
  pc_t                   miss_pc;
  logic                  do_call;
  pc_t                   ret_pc;
  logic                  do_ret;
  logic                  commit_valid;
  pc_t                   commit_pc;
  slot_vec_t             commit_takb;
  pc_t [`BTB_SLOTS-1:0]  commit_tgt;
  pc_t                   fetch_pc;
  slot_vec_t             takb;

  // ============================================================
  // reference model state
  // ============================================================
  pc_t                   model_pc;            // predicted fetch_pc
  pc_t                   bank_map [key_t];    // btb contents now
  pc_t                   seen_map [key_t];    // contents the current group read
  pc_t                   ras_q [$];           // front is top of stack
  logic                  pend_valid;          // commit waiting for its write edge
  pc_t                   pend_pc;
  slot_vec_t             pend_takb;
  pc_t [`BTB_SLOTS-1:0]  pend_tgt;
  pc_t                   bases [$];           // committed group bases

  int errors;
  int checks;
  int test_start;                             // error count at test start

  btb_fetch_top btb_fetch_top_i (
    .clk          (clk),
    .rst          (rst),
    .fetch_en     (fetch_en),
    .adv          (adv),
    .insn_count   (insn_count),
    .miss_valid   (miss_valid),
    .miss_pc      (miss_pc),
    .do_call      (do_call),
    .ret_pc       (ret_pc),
    .do_ret       (do_ret),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_takb  (commit_takb),
    .commit_tgt   (commit_tgt),
    .fetch_pc     (fetch_pc),
    .takb         (takb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                    // 8 ns period
  end

  function automatic key_t slot_key(int slot, pc_t pc);
    return {SLOT_W'(slot), pc};
  endfunction

  function automatic pc_t slot_addr(pc_t base, int slot);
    return base + pc_t'(slot * `INSN_BYTES);
  endfunction

  // lowest slot of the current group with a visible taken entry or -1
  function automatic int lowest_hit();
    int found;
    found = -1;
    if (fetch_en) begin
      for (int i = `BTB_SLOTS - 1; i >= 0; i--) begin
        if (seen_map.exists(slot_key(i, slot_addr(model_pc, i)))) begin
          found = i;
        end
      end
    end
    return found;
  endfunction

  task automatic check(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("CHECK FAILED at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    if (errors == test_start) begin
      $display("test %s ok", name);
    end else begin
      $display("test %s FAILED with %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  task automatic idle_inputs();
    fetch_en     = 1'b1;
    adv          = 1'b0;
    insn_count   = '0;
    miss_valid   = 1'b0;
    miss_pc      = '0;
    do_call      = 1'b0;
    ret_pc       = '0;
    do_ret       = 1'b0;
    commit_valid = 1'b0;
    commit_pc    = '0;
    commit_takb  = '0;
    commit_tgt   = '0;
  endtask

  // runs one clock and checks takb before and fetch_pc after the edge
  task automatic cycle();
    int        slot;
    pc_t       nxt;
    slot_vec_t exp_takb;
    #1;                                       // inputs settle through the comb path
    slot = lowest_hit();
    exp_takb = '0;
    if (slot >= 0 && !do_ret && !miss_valid) begin
      exp_takb = slot_vec_t'(1) << slot;
    end
    check(takb == exp_takb, $sformatf("takb %b, expected %b", takb, exp_takb));
    nxt = model_pc;
    if (do_ret) begin
      if (ras_q.size() > 0) begin
        nxt = ras_q.pop_front();
      end
    end else if (miss_valid) begin
      nxt = miss_pc;
    end else if (!adv) begin
      nxt = model_pc;                         // back-pressure
    end else if (slot >= 0) begin
      nxt = seen_map[slot_key(slot, slot_addr(model_pc, slot))];
    end else begin
      nxt = model_pc + pc_t'(`INSN_BYTES * (int'(insn_count) + 1));
    end
    if (do_call && !do_ret) begin
      ras_q.push_front(ret_pc);
    end
    // new group reads the banks before this edge's write lands
    seen_map = bank_map;
    if (pend_valid) begin
      for (int i = 0; i < `BTB_SLOTS; i++) begin
        if (pend_takb[i]) begin
          bank_map[slot_key(i, slot_addr(pend_pc, i))] = pend_tgt[i];
        end
      end
    end
    pend_valid = commit_valid;
    pend_pc    = commit_pc;
    pend_takb  = commit_takb;
    pend_tgt   = commit_tgt;
    @(posedge clk);
    @(negedge clk);
    model_pc = nxt;
    check(fetch_pc == model_pc, $sformatf("fetch_pc %h, expected %h", fetch_pc, model_pc));
  endtask

  // step until the group shows a prediction
  task automatic wait_takb(input int limit);
    int n;
    n = 0;
    #1;
    while (takb == '0 && n < limit) begin
      cycle();
      n++;
      #1;
    end
    if (takb == '0) begin
      $display("timeout while waiting %0d cycles for a btb hit at pc %h", limit, fetch_pc);
      errors++;
    end
  endtask

  initial begin : main
    pc_t pushed [$];
    pc_t base;
    pc_t mpc;
    int  first;
    int  n;
    void'($urandom(553));
    errors     = 0;
    checks     = 0;
    test_start = 0;
    model_pc   = `RESET_PC;
    pend_valid = 1'b0;
    idle_inputs();
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // ============================================================
    // reset state and sequential advance
    // ============================================================
    #1;
    check(fetch_pc == `RESET_PC, $sformatf("fetch_pc %h after reset", fetch_pc));
    check(takb == '0, $sformatf("takb %b after reset", takb));
    report_test("reset state");

    for (int k = 0; k < 40; k++) begin
      adv        = 1'($urandom);
      insn_count = insn_count_t'($urandom);
      cycle();
    end
    report_test("sequential advance");

    // ============================================================
    // commit then miss to the group base and follow the hit
    // ============================================================
    for (int r = 0; r < 3; r++) begin
      base = pc_t'($urandom);
      base[`BTB_INDEX_LSB +: IDX_W] = IDX_W'(r * 97 + 3);   // distinct index per group
      commit_takb = slot_vec_t'($urandom);
      if (commit_takb == '0) begin
        commit_takb = slot_vec_t'(1) << (r % `BTB_SLOTS);
      end
      first = 0;
      for (int i = `BTB_SLOTS - 1; i >= 0; i--) begin
        if (commit_takb[i]) begin
          first = i;
        end
      end
      for (int i = 0; i < `BTB_SLOTS; i++) begin
        commit_tgt[i] = pc_t'($urandom);
      end
      commit_pc    = base;
      commit_valid = 1'b1;
      adv          = 1'b0;
      cycle();
      commit_valid = 1'b0;
      cycle();
      cycle();
      miss_valid = 1'b1;
      miss_pc    = base;
      cycle();
      check(fetch_pc == base, $sformatf("redirect to base %h gave %h", base, fetch_pc));
      miss_valid = 1'b0;
      adv        = 1'b1;
      wait_takb(2);
      check(takb == (slot_vec_t'(1) << first), $sformatf("takb %b at slot %0d", takb, first));
      cycle();
      check(fetch_pc == commit_tgt[first], $sformatf("target %h not taken", commit_tgt[first]));
      bases.push_back(base);
    end
    report_test("btb hit");

    // ============================================================
    // fetch enable gating and miss over a hitting group
    // ============================================================
    for (int r = 0; r < 8; r++) begin
      miss_valid = 1'b1;
      miss_pc    = bases[r % bases.size()];
      adv        = 1'b1;
      cycle();
      miss_valid = 1'b0;
      wait_takb(2);                            // group now predicts taken
      fetch_en   = 1'b0;                       // disabled fetch drops the prediction
      adv        = 1'b0;
      cycle();
      fetch_en   = 1'b1;
      mpc        = pc_t'($urandom);
      miss_valid = 1'b1;
      miss_pc    = mpc;
      adv        = 1'($urandom);
      #1;
      check(takb == '0, $sformatf("takb %b while miss is high", takb));
      cycle();
      check(fetch_pc == mpc, $sformatf("miss pc %h not loaded, got %h", mpc, fetch_pc));
      miss_valid = 1'b0;
    end
    report_test("miss redirect");

    // ============================================================
    // calls then returns in lifo order
    // ============================================================
    for (int r = 0; r < 6; r++) begin
      n = 2 + int'($urandom % 6);
      pushed.delete();
      adv     = 1'b1;
      do_call = 1'b1;
      for (int k = 0; k < n; k++) begin
        ret_pc = pc_t'($urandom);
        pushed.push_back(ret_pc);
        cycle();
      end
      do_call = 1'b0;
      do_ret  = 1'b1;
      for (int k = 0; k < n; k++) begin
        do_call = (k == 1);                    // same-cycle call must not push
        ret_pc  = pc_t'($urandom);
        cycle();
        check(fetch_pc == pushed[n-1-k], $sformatf("return %0d went to %h", k, fetch_pc));
      end
      do_ret  = 1'b0;
      do_call = 1'b0;
    end
    report_test("return stack");

    $display("checks: %0d run, %0d failed", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
fetch_pkg.sv
btb_pkg.sv
btb_ifs.sv
btb_commit_stage.sv
btb_bank.sv
btb_lookup_stage.sv
return_stack.sv
next_pc_select.sv
btb_fetch_top.sv
tb_btb_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the btb fetch testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_btb_fetch -Mdir "$OBJ" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
